//--- centipede_pkg.sv
package centipede_pkg;

	// cpu side widths
	typedef logic [13:0] addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  blk_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0]  axil_strb_t;
	typedef logic [1:0]  axil_resp_t;

	// 1 KB blocks, picked by addr[13:10]
	localparam blk_t BLK_PF     = 4'd1;
	localparam blk_t BLK_SW     = 4'd2;
	localparam blk_t BLK_IN     = 4'd3;
	localparam blk_t BLK_IRQACK = 4'd6;
	localparam blk_t BLK_OUT0   = 4'd7;

	localparam axil_resp_t RESP_OKAY = 2'b00;

	// cycles from ar handshake to rvalid
	localparam int READ_LATENCY = 2;

	typedef struct packed {
		logic       awvalid;
		addr_t      awaddr;
		logic       wvalid;
		axil_data_t wdata;
		axil_strb_t wstrb;
		logic       bready;
		logic       arvalid;
		addr_t      araddr;
		logic       rready;
	} axil_req_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		axil_resp_t bresp;
		logic       arready;
		logic       rvalid;
		axil_data_t rdata;
		axil_resp_t rresp;
	} axil_rsp_t;

	// one-cycle write strobe from the decoder to every target
	typedef struct packed {
		logic  en;
		blk_t  blk;
		addr_t addr;
		byte_t data;
	} cpu_wr_t;

	typedef struct packed {
		logic coin_r;
		logic coin_c;
		logic coin_l;
		logic self_test;
		logic cocktail;
		logic slam;
		logic start2;
		logic start1;
		logic fire2;
		logic fire1;
	} player_in_t;

	typedef logic [7:0] out_latch_t;

endpackage

//--- video_pkg.sv
package video_pkg;

	typedef logic [8:0] hcount_t;
	typedef logic [7:0] vcount_t;

	// one clock per pixel, 384 clocks per line
	localparam hcount_t H_TOTAL     = 9'd384;
	localparam hcount_t H_ACTIVE    = 9'd256;
	localparam hcount_t HSYNC_START = 9'd288;
	localparam hcount_t HSYNC_END   = 9'd320;

	// full 8 bit line count, so the counter wraps on its own
	localparam int      V_TOTAL     = 256;
	localparam vcount_t V_ACTIVE    = 8'd240;
	localparam vcount_t VSYNC_START = 8'd244;
	localparam vcount_t VSYNC_END   = 8'd248;

	// irq on lines 48, 112, 176, 240
	localparam vcount_t IRQ_LINE_MASK  = 8'd63;
	localparam vcount_t IRQ_LINE_PHASE = 8'd48;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
		logic line_start;
	} sync_t;

endpackage

//--- sync_gen.sv
`timescale 1ns/1ps

module sync_gen (
	input  logic              s_6mhz,
	input  logic              reset,
	output video_pkg::sync_t   sync_o,
	output video_pkg::hcount_t h_o,
	output video_pkg::vcount_t v_o
);
	import video_pkg::*;

	hcount_t h_q;
	hcount_t h_next;
	vcount_t v_q;
	vcount_t v_next;
	sync_t   sync_q;
	sync_t   sync_next;

	// next raster position
	always_comb
	begin
		h_next = h_q + 1'b1;
		v_next = v_q;
		if (h_q == H_TOTAL - 1'b1)
		begin
			h_next = '0;
			if (v_q == vcount_t'(V_TOTAL - 1))
				v_next = '0;
			else
				v_next = v_q + 1'b1;
		end
	end

	// decode windows from the next count
	// so the registered flags line up with h_q and v_q
	always_comb
	begin
		sync_next.hsync      = (h_next >= HSYNC_START) && (h_next < HSYNC_END);
		sync_next.hblank     = (h_next >= H_ACTIVE);
		sync_next.vsync      = (v_next >= VSYNC_START) && (v_next < VSYNC_END);
		sync_next.vblank     = (v_next >= V_ACTIVE);
		sync_next.line_start = (h_next == '0);
	end

	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			h_q    <= '0;
			v_q    <= '0;
			// all flags idle until the first real edge
			sync_q <= '0;
		end
		else
		begin
			h_q    <= h_next;
			v_q    <= v_next;
			sync_q <= sync_next;
		end
	end

	assign sync_o = sync_q;
	assign h_o    = h_q;
	assign v_o    = v_q;

	// horizontal count never leaves the line
	a_h_range: assert property (@(posedge s_6mhz) disable iff (reset)
		h_q < H_TOTAL);

endmodule

//--- axil_decoder.sv
`timescale 1ns/1ps

module axil_decoder (
	input  logic                    s_6mhz,
	input  logic                    reset,
	input  centipede_pkg::axil_req_t req_i,
	output centipede_pkg::axil_rsp_t rsp_o,
	output centipede_pkg::cpu_wr_t   wr_o,
	output logic                    rd_en_o,
	output centipede_pkg::blk_t      rd_blk_o,
	output centipede_pkg::addr_t     rd_addr_o,
	input  centipede_pkg::byte_t     pf_rdata_i,
	input  centipede_pkg::byte_t     io_rdata_i
);
	import centipede_pkg::*;

	// read FSM accepts, waits for the target byte and holds the response
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_FETCH,
		RD_RESP
	} rd_state_e;

	rd_state_e rd_state;
	logic      bvalid_q;
	logic      aw_hs;
	logic      ar_hs;
	blk_t      rd_blk_q;
	byte_t     rd_sel;
	byte_t     rdata_q;

	// aw and w taken together and only with no b pending
	assign aw_hs = req_i.awvalid && req_i.wvalid && !bvalid_q;

	// one read in flight so back-pressure on r blocks the next
	assign ar_hs = req_i.arvalid && (rd_state == RD_IDLE);

	// write strobe to targets in the acceptance cycle
	// only byte lane 0 carries data
	always_comb
	begin
		wr_o.en   = aw_hs && req_i.wstrb[0];
		wr_o.blk  = req_i.awaddr[13:10];
		wr_o.addr = req_i.awaddr;
		wr_o.data = req_i.wdata[7:0];
	end

	// read request goes out in the ar cycle
	assign rd_en_o   = ar_hs;
	assign rd_blk_o  = req_i.araddr[13:10];
	assign rd_addr_o = req_i.araddr;

	// pick return byte by the block carried through the pipe
	always_comb
	begin
		case (rd_blk_q)
			BLK_PF:  rd_sel = pf_rdata_i;
			BLK_SW,
			BLK_IN:  rd_sel = io_rdata_i;
			// unmapped reads as zero
			default: rd_sel = '0;
		endcase
	end

	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			bvalid_q <= 1'b0;
		else if (aw_hs)
			bvalid_q <= 1'b1;
		else if (req_i.bready)
			bvalid_q <= 1'b0;
	end

	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			rd_state <= RD_IDLE;
			rd_blk_q <= '0;
		end
		else
		begin
			case (rd_state)
				RD_IDLE:
				begin
					if (ar_hs)
					begin
						rd_blk_q <= rd_blk_o;
						rd_state <= RD_FETCH;
					end
				end
				// target byte is valid now
				RD_FETCH: rd_state <= RD_RESP;
				RD_RESP:
				begin
					if (req_i.rready)
						rd_state <= RD_IDLE;
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// response data loaded once per read
	always_ff @(posedge s_6mhz)
	begin
		if (rd_state == RD_FETCH)
			rdata_q <= rd_sel;
	end

	always_comb
	begin
		rsp_o         = '0;
		rsp_o.awready = aw_hs;
		rsp_o.wready  = aw_hs;
		rsp_o.bvalid  = bvalid_q;
		rsp_o.bresp   = RESP_OKAY;
		rsp_o.arready = (rd_state == RD_IDLE);
		rsp_o.rvalid  = (rd_state == RD_RESP);
		rsp_o.rdata   = {24'd0, rdata_q};
		rsp_o.rresp   = RESP_OKAY;
	end

	// valid holds until its ready
	a_bvalid_hold: assert property (@(posedge s_6mhz) disable iff (reset)
		bvalid_q && !req_i.bready |=> bvalid_q);
	a_rvalid_hold: assert property (@(posedge s_6mhz) disable iff (reset)
		rsp_o.rvalid && !req_i.rready |=> rsp_o.rvalid && $stable(rdata_q));

endmodule

//--- playfield_ram.sv
`timescale 1ns/1ps

module playfield_ram (
	input  logic                  s_6mhz,
	input  centipede_pkg::cpu_wr_t wr_i,
	input  logic                  rd_en_i,
	input  centipede_pkg::blk_t    rd_blk_i,
	input  centipede_pkg::addr_t   rd_addr_i,
	output centipede_pkg::byte_t   rdata_o
);
	import centipede_pkg::*;

	// 256 words of four byte lanes
	// lane layout kept from the board, the video fetch took a whole word
	byte_t [3:0] mem [0:255];

	logic [7:0] wr_idx;
	logic [1:0] wr_lane;
	logic [7:0] rd_idx;
	logic [1:0] rd_lane;
	logic       wr_sel;
	logic       rd_sel;
	byte_t      rdata_q;

	// word index from addr[9:6] and addr[3:0], lane from addr[5:4]
	assign wr_idx  = {wr_i.addr[9:6], wr_i.addr[3:0]};
	assign wr_lane = wr_i.addr[5:4];
	assign rd_idx  = {rd_addr_i[9:6], rd_addr_i[3:0]};
	assign rd_lane = rd_addr_i[5:4];

	assign wr_sel = wr_i.en && (wr_i.blk == BLK_PF);
	assign rd_sel = rd_en_i && (rd_blk_i == BLK_PF);

	// single lane write
	always_ff @(posedge s_6mhz)
	begin
		if (wr_sel)
			mem[wr_idx][wr_lane] <= wr_i.data;
	end

	// registered lane read, one cycle after the request
	always_ff @(posedge s_6mhz)
	begin
		if (rd_sel)
			rdata_q <= mem[rd_idx][rd_lane];
	end

	assign rdata_o = rdata_q;

endmodule

//--- io_ports.sv
`timescale 1ns/1ps

module io_ports (
	input  logic                     s_6mhz,
	input  logic                     reset,
	input  centipede_pkg::cpu_wr_t    wr_i,
	input  logic                     rd_en_i,
	input  centipede_pkg::blk_t       rd_blk_i,
	input  centipede_pkg::addr_t      rd_addr_i,
	output centipede_pkg::byte_t      rdata_o,
	input  video_pkg::sync_t          sync_i,
	input  video_pkg::vcount_t        v_i,
	input  centipede_pkg::player_in_t player_i,
	input  centipede_pkg::byte_t      sw1_i,
	input  centipede_pkg::byte_t      sw2_i,
	output logic [4:1]               led_o,
	output logic [2:0]               coin_ctr_o,
	output logic                     flip_o,
	output logic                     irq_o
);
	import centipede_pkg::*;
	import video_pkg::*;

	out_latch_t latch_q;
	byte_t      in0;
	byte_t      in1;
	byte_t      rd_mux;
	byte_t      rdata_q;
	logic       irq_q;
	logic       irq_set;
	logic       irq_ack;

	// in0: vblank plus cabinet bits, trakball nibble gone
	assign in0 = {1'b0, sync_i.vblank, player_i.self_test, player_i.cocktail, 4'b0000};

	// in1: a driven coin counter reads back as a coin
	assign in1 = {
		player_i.coin_r | latch_q[2],
		player_i.coin_c | latch_q[1],
		player_i.coin_l | latch_q[0],
		player_i.slam,
		player_i.fire2,
		player_i.fire1,
		player_i.start2,
		player_i.start1
	};

	always_comb
	begin
		case (rd_blk_i)
			// addr bit 0 picks the option bank
			BLK_SW:  rd_mux = rd_addr_i[0] ? sw2_i : sw1_i;
			// addr bit 1 picks the player port
			BLK_IN:  rd_mux = rd_addr_i[1] ? in1 : in0;
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge s_6mhz)
	begin
		if (rd_en_i)
			rdata_q <= rd_mux;
	end

	assign rdata_o = rdata_q;

	// addressable latch, addr[2:0] picks the bit, data bit 7 is the value
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			latch_q <= '0;
		else if (wr_i.en && (wr_i.blk == BLK_OUT0))
			latch_q[wr_i.addr[2:0]] <= wr_i.data[7];
	end

	// right, center, left counters
	assign coin_ctr_o = latch_q[2:0];
	assign led_o      = latch_q[6:3];
	assign flip_o     = latch_q[7];

	// raise on the first clock of every 64th line from 48
	assign irq_set = sync_i.line_start && ((v_i & IRQ_LINE_MASK) == IRQ_LINE_PHASE);
	assign irq_ack = wr_i.en && (wr_i.blk == BLK_IRQACK);

	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			irq_q <= 1'b0;
		// a new line wins over a same-cycle ack
		else if (irq_set)
			irq_q <= 1'b1;
		else if (irq_ack)
			irq_q <= 1'b0;
	end

	assign irq_o = irq_q;

	// irq only comes up off the line start of sync_gen
	a_irq_at_line: assert property (@(posedge s_6mhz) disable iff (reset)
		$rose(irq_q) |-> $past(sync_i.line_start));

endmodule

//--- centipede_top.sv
`timescale 1ns/1ps

module centipede_top (
	input  logic                     s_6mhz,
	input  logic                     reset,
	input  centipede_pkg::axil_req_t  axil_req_i,
	output centipede_pkg::axil_rsp_t  axil_rsp_o,
	input  centipede_pkg::player_in_t player_i,
	input  centipede_pkg::byte_t      sw1_i,
	input  centipede_pkg::byte_t      sw2_i,
	output logic                     hsync_o,
	output logic                     vsync_o,
	output logic                     hblank_o,
	output logic                     vblank_o,
	output logic                     sync_o,
	output logic                     irq_o,
	output logic [4:1]               led_o,
	output logic [2:0]               coin_ctr_o,
	output logic                     flip_o
);
	import centipede_pkg::*;
	import video_pkg::*;

	sync_t   sync;
	vcount_t v_count;
	cpu_wr_t cpu_wr;
	logic    rd_en;
	blk_t    rd_blk;
	addr_t   rd_addr;
	byte_t   pf_rdata;
	byte_t   io_rdata;

	// raster timing, pixel count unused without video
	sync_gen u_sync_gen (
		.s_6mhz (s_6mhz),
		.reset  (reset),
		.sync_o (sync),
		.h_o    (),
		.v_o    (v_count)
	);

	// bus front end in place of the 6502
	axil_decoder u_axil_decoder (
		.s_6mhz     (s_6mhz),
		.reset      (reset),
		.req_i      (axil_req_i),
		.rsp_o      (axil_rsp_o),
		.wr_o       (cpu_wr),
		.rd_en_o    (rd_en),
		.rd_blk_o   (rd_blk),
		.rd_addr_o  (rd_addr),
		.pf_rdata_i (pf_rdata),
		.io_rdata_i (io_rdata)
	);

	playfield_ram u_playfield_ram (
		.s_6mhz    (s_6mhz),
		.wr_i      (cpu_wr),
		.rd_en_i   (rd_en),
		.rd_blk_i  (rd_blk),
		.rd_addr_i (rd_addr),
		.rdata_o   (pf_rdata)
	);

	io_ports u_io_ports (
		.s_6mhz     (s_6mhz),
		.reset      (reset),
		.wr_i       (cpu_wr),
		.rd_en_i    (rd_en),
		.rd_blk_i   (rd_blk),
		.rd_addr_i  (rd_addr),
		.rdata_o    (io_rdata),
		.sync_i     (sync),
		.v_i        (v_count),
		.player_i   (player_i),
		.sw1_i      (sw1_i),
		.sw2_i      (sw2_i),
		.led_o      (led_o),
		.coin_ctr_o (coin_ctr_o),
		.flip_o     (flip_o),
		.irq_o      (irq_o)
	);

	assign hsync_o  = sync.hsync;
	assign vsync_o  = sync.vsync;
	assign hblank_o = sync.hblank;
	assign vblank_o = sync.vblank;
	// composite sync, low during either pulse
	assign sync_o   = ~(sync.hsync | sync.vsync);

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
	input  logic                     s_6mhz_i,
	input  logic                     reset_i,
	input  centipede_pkg::axil_req_t  req_i,
	input  centipede_pkg::axil_rsp_t  rsp_i,
	input  centipede_pkg::player_in_t player_i,
	input  centipede_pkg::byte_t      sw1_i,
	input  centipede_pkg::byte_t      sw2_i,
	input  logic                     hsync_i,
	input  logic                     vsync_i,
	input  logic                     hblank_i,
	input  logic                     vblank_i,
	input  logic                     sync_i,
	input  logic                     irq_i,
	input  logic [4:1]               led_i,
	input  logic [2:0]               coin_i,
	input  logic                     flip_i,
	output int                       errs_o,
	output int                       checks_o,
	output int                       sync_cnt_o
);
	import centipede_pkg::*;
	import video_pkg::*;

	// byte model of the playfield indexed by addr[9:0]
	byte_t      pf_m [0:1023];
	logic       pf_v [0:1023];
	out_latch_t latch_m;
	logic       rd_busy;
	logic       rd_known;
	logic       lat_done;
	byte_t      rd_exp;
	int         rd_wait;
	logic [31:0] rdata_q;
	int         cyc;
	int         hs_rise;
	int         hb_rise;
	int         lines_vs;
	int         lines_vb;
	int         line_est;
	logic       hs_seen;
	logic       hb_seen;
	logic       vs_seen;
	logic       vb_seen;
	logic       line_ok;
	logic       idle_done;
	logic       ack_now;
	logic       hs_q;
	logic       hb_q;
	logic       vs_q;
	logic       vb_q;
	logic       irq_q;
	logic       ack_q;
	logic       aw_q;
	logic       bv_q;
	logic       br_q;
	logic       rv_q;
	logic       rr_q;

	// expected read byte from the board rules
	function automatic byte_t ref_read(input addr_t a, output logic known);
		byte_t r;
		known = 1'b1;
		r = '0;
		case (a[13:10])
			BLK_PF:
			begin
				known = pf_v[a[9:0]];
				r = pf_m[a[9:0]];
			end
			BLK_SW: r = a[0] ? sw2_i : sw1_i;
			BLK_IN:
			begin
				if (a[1])
					r = {player_i.coin_r | latch_m[2], player_i.coin_c | latch_m[1],
						player_i.coin_l | latch_m[0], player_i.slam, player_i.fire2,
						player_i.fire1, player_i.start2, player_i.start1};
				else
					r = {1'b0, vblank_i, player_i.self_test, player_i.cocktail, 4'b0000};
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic fail_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
		errs_o++;
		$display("ERROR %s got %h expected %h at %0t", sig, got, exp, $time);
	endtask

	task automatic fail_msg(input string what);
		errs_o++;
		$display("failure at %0t: %s", $time, what);
	endtask

	task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
		checks_o++;
		if (got !== exp)
			fail_val(sig, got, exp);
	endtask

	initial
	begin
		errs_o     = 0;
		checks_o   = 0;
		sync_cnt_o = 0;
		for (int i = 0; i < 1024; i++)
			pf_v[i] = 1'b0;
	end

	// sample mid cycle where everything has settled
	always @(negedge s_6mhz_i)
	begin
		if (reset_i)
		begin
			latch_m   = '0;
			rd_busy   = 1'b0;
			cyc       = 0;
			hs_seen   = 1'b0;
			hb_seen   = 1'b0;
			vs_seen   = 1'b0;
			vb_seen   = 1'b0;
			line_ok   = 1'b0;
			idle_done = 1'b0;
			{hs_q, hb_q, vs_q, vb_q, irq_q, ack_q, aw_q, bv_q, br_q, rv_q, rr_q} = '0;
		end
		else
		begin
			cyc++;
			// outputs idle after reset
			if (!idle_done)
			begin
				check_val("bvalid", 32'(rsp_i.bvalid), 32'd0);
				check_val("rvalid", 32'(rsp_i.rvalid), 32'd0);
				check_val("irq_o", 32'(irq_i), 32'd0);
				check_val("outputs", {24'd0, led_i, coin_i, flip_i}, 32'd0);
				idle_done = 1'b1;
			end
			// latch outputs trail the model by one sample
			if ({led_i, coin_i, flip_i} !== {latch_m[6:3], latch_m[2:0], latch_m[7]})
				fail_val("led_o/coin_ctr_o/flip_o", {24'd0, led_i, coin_i, flip_i},
					{24'd0, latch_m[6:3], latch_m[2:0], latch_m[7]});
			if (sync_i !== ~(hsync_i | vsync_i))
				fail_val("sync_o", 32'(sync_i), 32'(~(hsync_i | vsync_i)));

			// frame level widths counted in hsync pulses
			if (vsync_i && !vs_q)
			begin
				lines_vs = 0;
				vs_seen  = 1'b1;
			end
			if (!vsync_i && vs_q && vs_seen)
			begin
				check_val("vsync_o lines", 32'(lines_vs), 32'(VSYNC_END - VSYNC_START));
				sync_cnt_o++;
				line_est = int'(VSYNC_END);
				line_ok  = 1'b1;
			end
			if (vblank_i && !vb_q)
			begin
				lines_vb = 0;
				vb_seen  = 1'b1;
			end
			if (!vblank_i && vb_q && vb_seen)
			begin
				check_val("vblank_o lines", 32'(lines_vb), 32'(V_TOTAL - int'(V_ACTIVE)));
				sync_cnt_o++;
			end
			if (hsync_i && !hs_q)
			begin
				if (hs_seen)
					check_val("hsync_o period", 32'(cyc - hs_rise), 32'(H_TOTAL));
				hs_rise  = cyc;
				hs_seen  = 1'b1;
				lines_vs = lines_vs + int'(vsync_i);
				lines_vb = lines_vb + int'(vblank_i);
				line_est = (line_est + 1) % 256;
			end
			if (!hsync_i && hs_q && hs_seen)
				check_val("hsync_o width", 32'(cyc - hs_rise), 32'(HSYNC_END - HSYNC_START));
			if (hblank_i && !hb_q)
			begin
				hb_rise = cyc;
				hb_seen = 1'b1;
			end
			if (!hblank_i && hb_q && hb_seen)
				check_val("hblank_o width", 32'(cyc - hb_rise), 32'(H_TOTAL - H_ACTIVE));

			// irq against the estimated line
			if (irq_i && !irq_q && line_ok)
			begin
				checks_o++;
				if (((line_est - int'(IRQ_LINE_PHASE)) & int'(IRQ_LINE_MASK)) > 1)
					fail_msg($sformatf("irq_o rose on line %0d", line_est));
			end
			if (!irq_i && irq_q && !ack_q)
				fail_msg("irq_o dropped without an acknowledge write");
			if (irq_i && irq_q && ack_q)
				fail_msg("irq_o stayed set after the acknowledge write");

			// aw and w are taken in the same cycle
			if (rsp_i.wready !== rsp_i.awready)
				fail_val("wready", 32'(rsp_i.wready), 32'(rsp_i.awready));
			if (aw_q && !rsp_i.bvalid)
				fail_msg("bvalid did not rise in the cycle after the write acceptance");
			if (bv_q && !br_q && !rsp_i.bvalid)
				fail_msg("bvalid dropped without bready");
			if (rv_q && !rr_q)
			begin
				if (!rsp_i.rvalid)
					fail_msg("rvalid dropped without rready");
				else if (rsp_i.rdata !== rdata_q)
					fail_val("rdata held", rsp_i.rdata, rdata_q);
			end

			// arready only while no read is outstanding
			if (rsp_i.arready !== !rd_busy)
				fail_val("arready", 32'(rsp_i.arready), 32'(!rd_busy));

			// read in flight
			if (rd_busy)
			begin
				rd_wait++;
				if (rsp_i.rvalid && !lat_done)
				begin
					check_val("read latency", 32'(rd_wait), 32'(READ_LATENCY));
					lat_done = 1'b1;
				end
				if (rsp_i.rvalid && req_i.rready)
				begin
					if (rd_known)
						check_val("rdata", rsp_i.rdata, {24'd0, rd_exp});
					check_val("rresp", 32'(rsp_i.rresp), 32'(RESP_OKAY));
					rd_busy = 1'b0;
				end
			end
			if (req_i.arvalid && rsp_i.arready)
			begin
				rd_exp   = ref_read(req_i.araddr, rd_known);
				rd_busy  = 1'b1;
				lat_done = 1'b0;
				rd_wait  = 0;
			end

			// writes land in the models after the read sample
			ack_now = 1'b0;
			if (req_i.awvalid && rsp_i.awready && req_i.wstrb[0])
			begin
				case (req_i.awaddr[13:10])
					BLK_PF:
					begin
						pf_m[req_i.awaddr[9:0]] = req_i.wdata[7:0];
						pf_v[req_i.awaddr[9:0]] = 1'b1;
					end
					BLK_OUT0: latch_m[req_i.awaddr[2:0]] = req_i.wdata[7];
					BLK_IRQACK: ack_now = 1'b1;
					default: ;
				endcase
			end
			if (rsp_i.bvalid && req_i.bready)
				check_val("bresp", 32'(rsp_i.bresp), 32'(RESP_OKAY));

			hs_q    = hsync_i;
			hb_q    = hblank_i;
			vs_q    = vsync_i;
			vb_q    = vblank_i;
			irq_q   = irq_i;
			ack_q   = ack_now;
			aw_q    = req_i.awvalid && rsp_i.awready;
			bv_q    = rsp_i.bvalid;
			br_q    = req_i.bready;
			rv_q    = rsp_i.rvalid;
			rr_q    = req_i.rready;
			rdata_q = rsp_i.rdata;
		end
	end

endmodule

//--- tb_centipede.sv
`timescale 1ns/1ps

module tb_centipede;
	import centipede_pkg::*;
	import video_pkg::*;

	localparam int TMO     = 1000;
	localparam int FRAME   = int'(H_TOTAL) * V_TOTAL;
	// clocks from one interrupt line to the next
	localparam int IRQ_GAP = (int'(IRQ_LINE_MASK) + 1) * int'(H_TOTAL);

	logic       s_6mhz;
	logic       reset;
	axil_req_t  req;
	axil_rsp_t  rsp;
	player_in_t player;
	byte_t      sw1;
	byte_t      sw2;
	logic       hsync;
	logic       vsync;
	logic       hblank;
	logic       vblank;
	logic       csync;
	logic       irq;
	logic [4:1] led;
	logic [2:0] coin;
	logic       flip;
	int         chk_errs;
	int         chk_count;
	int         sync_count;
	int         top_errs;
	int         n_tests;
	int         last_errs;
	logic [31:0] rng;
	addr_t      pf_addr [0:63];
	addr_t      a;
	int         n;
	int         hold;

	centipede_top DUT (
		.s_6mhz     (s_6mhz),
		.reset      (reset),
		.axil_req_i (req),
		.axil_rsp_o (rsp),
		.player_i   (player),
		.sw1_i      (sw1),
		.sw2_i      (sw2),
		.hsync_o    (hsync),
		.vsync_o    (vsync),
		.hblank_o   (hblank),
		.vblank_o   (vblank),
		.sync_o     (csync),
		.irq_o      (irq),
		.led_o      (led),
		.coin_ctr_o (coin),
		.flip_o     (flip)
	);

	tb_checker u_chk (
		.s_6mhz_i   (s_6mhz),
		.reset_i    (reset),
		.req_i      (req),
		.rsp_i      (rsp),
		.player_i   (player),
		.sw1_i      (sw1),
		.sw2_i      (sw2),
		.hsync_i    (hsync),
		.vsync_i    (vsync),
		.hblank_i   (hblank),
		.vblank_i   (vblank),
		.sync_i     (csync),
		.irq_i      (irq),
		.led_i      (led),
		.coin_i     (coin),
		.flip_i     (flip),
		.errs_o     (chk_errs),
		.checks_o   (chk_count),
		.sync_cnt_o (sync_count)
	);

	// 4 ns pixel clock
	always #2 s_6mhz = ~s_6mhz;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// inputs change half a ns past the edge
	task automatic step();
		@(posedge s_6mhz);
		#0.5;
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout waiting for %s", what);
		$display("Errors found");
		$finish;
	endtask

	task automatic axi_write(input addr_t wa, input byte_t d, input int bhold);
		int cnt;
		cnt = 0;
		req.awvalid = 1'b1;
		req.awaddr  = wa;
		req.wvalid  = 1'b1;
		req.wdata   = {24'd0, d};
		req.wstrb   = 4'hf;
		// ready looked at mid cycle
		#1;
		while (!rsp.awready)
		begin
			@(posedge s_6mhz);
			#1.5;
			cnt++;
			if (cnt > TMO)
				fail_timeout("awready");
		end
		step();
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
		cnt = 0;
		#1;
		while (!rsp.bvalid)
		begin
			@(posedge s_6mhz);
			#1.5;
			cnt++;
			if (cnt > TMO)
				fail_timeout("bvalid");
		end
		step();
		// back-pressure on b
		repeat (bhold) step();
		req.bready = 1'b1;
		step();
		req.bready = 1'b0;
	endtask

	task automatic axi_read(input addr_t ra, input int rhold);
		int cnt;
		cnt = 0;
		req.arvalid = 1'b1;
		req.araddr  = ra;
		#1;
		while (!rsp.arready)
		begin
			@(posedge s_6mhz);
			#1.5;
			cnt++;
			if (cnt > TMO)
				fail_timeout("arready");
		end
		step();
		req.arvalid = 1'b0;
		cnt = 0;
		#1;
		while (!rsp.rvalid)
		begin
			@(posedge s_6mhz);
			#1.5;
			cnt++;
			if (cnt > TMO)
				fail_timeout("rvalid");
		end
		step();
		repeat (rhold) step();
		req.rready = 1'b1;
		step();
		req.rready = 1'b0;
	endtask

	task automatic rand_inputs();
		rng    = xorshift(rng);
		player = player_in_t'(rng[9:0]);
		sw1    = rng[17:10];
		sw2    = rng[25:18];
	endtask

	task automatic end_test(input string name);
		int total;
		total = chk_errs + top_errs;
		n_tests++;
		$display("test %0d %s: %s, %0d errors", n_tests, name,
			(total == last_errs) ? "ok" : "failed", total - last_errs);
		last_errs = total;
	endtask

	initial
	begin
		s_6mhz    = 1'b0;
		reset     = 1'b1;
		req       = '0;
		player    = '0;
		sw1       = '0;
		sw2       = '0;
		top_errs  = 0;
		n_tests   = 0;
		last_errs = 0;
		rng       = 32'd47;
		repeat (3) @(posedge s_6mhz);
		#0.5;
		reset = 1'b0;
		step();

		// random bytes over the whole playfield block
		for (int i = 0; i < 64; i++)
		begin
			rng = xorshift(rng);
			pf_addr[i] = {BLK_PF, rng[9:0]};
			axi_write(pf_addr[i], rng[17:10], 0);
		end
		for (int i = 0; i < 64; i++)
			axi_read(pf_addr[i], 0);
		// four lanes of one word
		for (int l = 0; l < 4; l++)
		begin
			a = {BLK_PF, 10'h203};
			a[5:4] = 2'(l);
			axi_write(a, 8'ha0 + 8'(l), 0);
		end
		for (int l = 0; l < 4; l++)
		begin
			a = {BLK_PF, 10'h203};
			a[5:4] = 2'(l);
			axi_read(a, 0);
		end
		end_test("playfield ram");

		repeat (8)
		begin
			rand_inputs();
			step();
			axi_read({BLK_SW, 10'd0}, 0);
			axi_read({BLK_SW, 10'd1}, 0);
			axi_read({BLK_IN, 10'd0}, 0);
			axi_read({BLK_IN, 10'd2}, 0);
		end
		// in0 again once vblank has come up
		n = 0;
		while (!vblank)
		begin
			step();
			n++;
			if (n > FRAME)
				fail_timeout("vblank_o");
		end
		step();
		axi_read({BLK_IN, 10'd0}, 0);
		axi_read({BLK_IN, 10'd0}, 2);
		end_test("inputs and switches");

		player = '0;
		for (int i = 0; i < 8; i++)
		begin
			axi_write({BLK_OUT0, 10'(i)}, 8'h80, 0);
			repeat (2) step();
			axi_read({BLK_IN, 10'd2}, 0);
		end
		for (int i = 0; i < 8; i++)
		begin
			axi_write({BLK_OUT0, 10'(i)}, 8'h00, 0);
			axi_read({BLK_IN, 10'd2}, 0);
		end
		end_test("output latch");

		// two full frames of measurements
		n = 0;
		while (sync_count < 4)
		begin
			step();
			n++;
			if (n > 3 * FRAME)
				fail_timeout("sync measurements");
		end
		end_test("sync timing");

		repeat (3)
		begin
			n = 0;
			while (!irq)
			begin
				step();
				n++;
				if (n > IRQ_GAP)
					fail_timeout("irq_o");
			end
			repeat (20) step();
			axi_write({BLK_IRQACK, 10'd0}, 8'h00, 0);
			repeat (3) step();
			if (irq)
			begin
				$display("irq_o still set after the acknowledge write");
				top_errs++;
			end
		end
		end_test("interrupt");

		repeat (6)
		begin
			rng  = xorshift(rng);
			hold = int'(rng[3:0]);
			a    = {BLK_PF, rng[13:4]};
			axi_write(a, rng[21:14], hold);
			axi_read(a, int'(rng[25:22]));
		end
		// unmapped blocks read as zero
		axi_read({4'd0, 10'h011}, 3);
		axi_read({4'd4, 10'h000}, 0);
		axi_read({4'd9, 10'h3ff}, 5);
		axi_read({4'd15, 10'h155}, 1);
		end_test("handshake");

		$display("tests %0d, checks %0d, errors %0d", n_tests, chk_count,
			chk_errs + top_errs);
		if (chk_errs + top_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- compile.f
centipede_pkg.sv
video_pkg.sv
sync_gen.sv
axil_decoder.sv
playfield_ram.sv
io_ports.sv
centipede_top.sv
tb_checker.sv
tb_centipede.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_centipede -o sim_centipede > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/sim_centipede > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" sim.log; then
	exit 0
fi
exit 1
